/* files.f */
verilog/lcd_pkg.sv
verilog/lcd_fetch_if.sv
verilog/display_text_gen.sv
verilog/lcd_frame_buffer.sv
verilog/lcd_timer.sv
verilog/lcd_sequencer.sv
verilog/lcd_display_top.sv
verification/lcd_display_asserts.sv
verification/lcd_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LCD display testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lcd_display_tb \
   -f files.f -o sim_lcd_display
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_lcd_display > "$log" 2>&1
run_status=$?
cat "$log"

if grep -qF '*** FAILED ***' "$log"; then
   echo "Simulation reported a failure, see $log"
   exit 1
fi
if [ "$run_status" -ne 0 ]; then
   echo "Simulation exited with status $run_status, see $log"
   exit 1
fi
echo "Simulation finished without failures"
exit 0

/* verification/lcd_display_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_display_asserts import lcd_pkg::*; (
   input logic      clk,
   input logic      rst_n,
   input logic      lcd_en,
   input logic      lcd_rs,
   input lcd_char_t lcd_data
);

   timer_count_t en_run; // Cycles lcd_en has been high so far

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         en_run <= '0;
      end else begin
         en_run <= lcd_en ? en_run + 8'd1 : 8'd0;
      end
   end

   a_en_width: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(lcd_en) |-> en_run == LCD_EN_CYCLES)
      else $error("lcd_en pulse lasted %0d cycles", en_run);

   a_en_not_long: assert property (@(posedge clk) disable iff (!rst_n)
      lcd_en |-> en_run < LCD_EN_CYCLES)
      else $error("lcd_en stayed high too long");

   // The controller may latch at any point of the pulse
   a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
      lcd_en |-> $stable(lcd_data) && $stable(lcd_rs))
      else $error("lcd_data or lcd_rs moved while lcd_en was high");

   a_en_reset: assert property (@(posedge clk) !rst_n |-> !lcd_en)
      else $error("lcd_en high during reset");

endmodule

bind lcd_sequencer lcd_display_asserts i_lcd_display_asserts (
   .clk      (clk),
   .rst_n    (rst_n),
   .lcd_en   (lcd_en),
   .lcd_rs   (lcd_rs),
   .lcd_data (lcd_data)
);

`default_nettype wire

/* verification/lcd_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_display_tb import lcd_pkg::*; ();

   typedef struct packed {
      talk_mode_t talk;
      effect_t    effect;
      volume_t    vol;
      logic       vol_on;
      lcd_row_t   row_1;
      lcd_row_t   row_2;
   } entry_t;

   logic        clk = 1'b0;
   logic        rst_n;
   talk_mode_t  talk_state;
   effect_t     current_effect;
   volume_t     volume;
   logic        enable_volume;
   logic        lcd_en;
   logic        lcd_rs;
   logic        lcd_rw;
   lcd_char_t   lcd_data;

   entry_t      stim[$];
   lcd_cmd_t    init_order[INIT_CMD_COUNT] = '{CMD_FUNCTION_SET, CMD_DISPLAY_ON,
                                               CMD_ENTRY_MODE, CMD_CLEAR};
   lcd_cmd_t    init_log[INIT_CMD_COUNT];
   lcd_row_t    shadow_1;        // DDRAM contents as the controller would hold them
   lcd_row_t    shadow_2;
   logic [6:0]  ddram_addr;
   lcd_row_t    prev_1;          // Text of the entry before the one now applied
   lcd_row_t    prev_2;
   lcd_row_t    cur_1;
   lcd_row_t    cur_2;
   int          write_count = 0;
   int          frame_count = 0; // Steps on every row 1 address write
   int          cycle_count = 0;
   int          cycle_limit = 0;
   logic [31:0] rng = 32'he3cd88b2;

   lcd_display_top i_lcd_display_top (
      .clk            (clk),
      .rst_n          (rst_n),
      .talk_state     (talk_state),
      .current_effect (current_effect),
      .volume         (volume),
      .enable_volume  (enable_volume),
      .lcd_en         (lcd_en),
      .lcd_rs         (lcd_rs),
      .lcd_rw         (lcd_rw),
      .lcd_data       (lcd_data)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // A '#' in the table text stands for the solid block
   function automatic lcd_row_t text_row(input lcd_row_t text);
      lcd_row_t r;
      r = text;
      for (int i = 0; i < 16; i++) begin
         if (r[i] == 8'h23) begin
            r[i] = CHAR_FILL;
         end
      end
      return r;
   endfunction

   // Columns 0 through the volume level are lit
   function automatic lcd_row_t bar_row(input volume_t vol);
      lcd_row_t r;
      r = {16{CHAR_SPACE}};
      for (int c = 0; c <= int'(vol); c++) begin
         r[15 - c] = CHAR_FILL;
      end
      return r;
   endfunction

   function automatic entry_t make_entry(input talk_mode_t t, input effect_t e,
                                         input volume_t v, input logic on,
                                         input lcd_row_t r1, input lcd_row_t r2);
      entry_t en;
      en.talk   = t;
      en.effect = e;
      en.vol    = v;
      en.vol_on = on;
      en.row_1  = text_row(r1);
      en.row_2  = text_row(r2);
      return en;
   endfunction

   task automatic report_failure();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_cmd(input string name, input lcd_cmd_t exp, input lcd_cmd_t act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %h (%s) got %h", $time, name, exp, exp.name(), act);
         report_failure();
      end
   endtask

   task automatic check_char(input string name, input lcd_char_t exp, input lcd_char_t act);
      if (act !== exp) begin
         $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_row(input string name, input lcd_row_t exp, input lcd_row_t act);
      if (act !== exp) begin
         for (int c = 0; c < 16; c++) begin
            check_char($sformatf("%s column %0d", name, c), exp[15 - c], act[15 - c]);
         end
      end
   endtask

   // A finished frame holds one whole entry per row, the old one or the new one
   task automatic check_frame();
      if (shadow_1 !== prev_1) check_row("row_1", cur_1, shadow_1);
      if (shadow_2 !== prev_2) check_row("row_2", cur_2, shadow_2);
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frame_count + n;
      while (frame_count < target) @(posedge clk);
   endtask

   // The LCD controller latches rs and data on the falling edge of enable
   always @(negedge lcd_en) begin
      int pos;
      if (rst_n === 1'b1) begin
         check_level("lcd_rw", 1'b0, lcd_rw);
         if (write_count < INIT_CMD_COUNT) begin
            init_log[write_count] = lcd_cmd_t'(lcd_data);
            check_level("lcd_rs", 1'b0, lcd_rs);
            check_cmd("init command", init_order[write_count], init_log[write_count]);
            if (init_log[write_count] == CMD_CLEAR) begin
               shadow_1   = {16{CHAR_SPACE}};
               shadow_2   = {16{CHAR_SPACE}};
               ddram_addr = 7'h00;
            end
         end else begin
            pos = (write_count - INIT_CMD_COUNT) % 34; // Two address and 32 data writes
            if (pos == 0 || pos == 17) begin
               check_level("lcd_rs", 1'b0, lcd_rs);
               check_cmd("address command", (pos == 0) ? CMD_ROW1_ADDR : CMD_ROW2_ADDR,
                         lcd_cmd_t'(lcd_data));
               ddram_addr = (pos == 0) ? 7'h00 : 7'h40;
               if (pos == 0 && frame_count > 0) check_frame();
               if (pos == 0) frame_count++;
            end else begin
               check_level("lcd_rs", 1'b1, lcd_rs);
               if (ddram_addr[6]) shadow_2[4'd15 - ddram_addr[3:0]] = lcd_data;
               else shadow_1[4'd15 - ddram_addr[3:0]] = lcd_data;
               ddram_addr++;
            end
         end
         write_count++;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the LCD bus stopped delivering frames", cycle_count);
         report_failure();
      end
   end

   initial begin
      int delay;
      stim.push_back(make_entry(TALK, NORMAL, 4'd15, 1'b1, "NO EFFECT       ", "################"));
      stim.push_back(make_entry(TALK, ECHO, 4'd7, 1'b1, "ECHO            ", "########        "));
      stim.push_back(make_entry(TALK, TREMOLO, 4'd0, 1'b1, "TREMOLO         ", "#               "));
      stim.push_back(make_entry(TALK, REVERB, 4'd3, 1'b1, "REVERB          ", "####            "));
      stim.push_back(make_entry(TALK, SOFT, 4'd10, 1'b1, "SOFT            ", "###########     "));
      stim.push_back(make_entry(TALK, effect_t'(3'd5), 4'd12, 1'b0,
                                "################", "                "));
      stim.push_back(make_entry(TALK, effect_t'(3'd6), 4'd1, 1'b1,
                                "################", "##              "));
      stim.push_back(make_entry(TALK, effect_t'(3'd7), 4'd8, 1'b1,
                                "################", "#########       "));
      stim.push_back(make_entry(LIST, NORMAL, 4'd4, 1'b1, "LISTEN          ", "#####           "));
      stim.push_back(make_entry(LIST, SOFT, 4'd14, 1'b1, "LISTEN          ", "############### "));
      stim.push_back(make_entry(LIST, effect_t'(3'd7), 4'd9, 1'b0,
                                "LISTEN          ", "                "));
      stim.push_back(make_entry(TALK, ECHO, 4'd15, 1'b0, "ECHO            ", "                "));
      for (int k = 0; k < 8; k++) begin
         rng = xorshift32(rng);
         stim.push_back(make_entry(k[0] ? TALK : LIST, REVERB, volume_t'(rng[3:0]), 1'b1,
                                   k[0] ? "REVERB          " : "LISTEN          ",
                                   bar_row(volume_t'(rng[3:0]))));
      end
      cycle_limit = (stim.size() * 2 * 34 * 17 + 10 + int'(LCD_POWERUP_CYCLES)
                     + INIT_CMD_COUNT * 17 + int'(LCD_CLEAR_WAIT_CYCLES) + 34 * 17) * 3 / 2;

      talk_state     = stim[0].talk;
      current_effect = stim[0].effect;
      volume         = stim[0].vol;
      enable_volume  = stim[0].vol_on;
      prev_1 = stim[0].row_1;
      prev_2 = stim[0].row_2;
      cur_1  = stim[0].row_1;
      cur_2  = stim[0].row_2;
      rst_n  = 1'b0;
      repeat (10) begin
         @(posedge clk);
         check_level("lcd_en", 1'b0, lcd_en);
      end
      rst_n <= 1'b1;
      repeat (int'(LCD_POWERUP_CYCLES)) begin
         @(posedge clk);
         check_level("lcd_en", 1'b0, lcd_en); // Controller still powering up
      end
      wait_frames(1);

      foreach (stim[i]) begin
         rng   = xorshift32(rng);
         delay = int'(rng[7:0]); // Lands the change somewhere inside the frame
         repeat (delay) @(posedge clk);
         @(posedge clk);
         talk_state     <= stim[i].talk;
         current_effect <= stim[i].effect;
         volume         <= stim[i].vol;
         enable_volume  <= stim[i].vol_on;
         prev_1 = cur_1;
         prev_2 = cur_2;
         cur_1  = stim[i].row_1;
         cur_2  = stim[i].row_2;
         wait_frames(2);
         check_row("row_1", stim[i].row_1, shadow_1);
         check_row("row_2", stim[i].row_2, shadow_2);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/display_text_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module display_text_gen import lcd_pkg::*; (
   input  talk_mode_t talk_state,
   input  effect_t    current_effect,
   input  volume_t    volume,
   input  logic       enable_volume,
   output lcd_row_t   row_1,
   output lcd_row_t   row_2
);

   // Top row shows what the radio is doing
   always_comb begin
      if (talk_state == LIST) begin
         row_1 = {"LISTEN", {10{CHAR_SPACE}}}; // Effect does not matter while receiving
      end else begin
         case (current_effect)
            NORMAL:  row_1 = {"NO EFFECT", {7{CHAR_SPACE}}};
            ECHO:    row_1 = {"ECHO", {12{CHAR_SPACE}}};
            TREMOLO: row_1 = {"TREMOLO", {9{CHAR_SPACE}}};
            REVERB:  row_1 = {"REVERB", {10{CHAR_SPACE}}};
            SOFT:    row_1 = {"SOFT", {12{CHAR_SPACE}}};
            default: row_1 = {16{CHAR_FILL}}; // Unknown code, make it obvious on the glass
         endcase
      end
   end

   // Bottom row is a bar graph with one block per volume step
   always_comb begin
      row_2 = {16{CHAR_SPACE}};
      if (enable_volume) begin
         for (int i = 0; i < 16; i++) begin
            // Column 0 is always lit so that minimum volume still shows a block
            row_2[15 - i] = (32'(volume) >= i) ? CHAR_FILL : CHAR_SPACE;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/lcd_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_display_top import lcd_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  talk_mode_t talk_state,
   input  effect_t    current_effect,
   input  volume_t    volume,
   input  logic       enable_volume, // Low when muted
   output logic       lcd_en,
   output logic       lcd_rs,
   output logic       lcd_rw,
   output lcd_char_t  lcd_data
);

   lcd_row_t     row_1;
   lcd_row_t     row_2;
   logic         timer_start;
   timer_count_t timer_cycles;
   logic         timer_done;

   lcd_fetch_if i_fetch_if ();

   display_text_gen i_display_text_gen (
      .talk_state     (talk_state),
      .current_effect (current_effect),
      .volume         (volume),
      .enable_volume  (enable_volume),
      .row_1          (row_1),
      .row_2          (row_2)
   );

   lcd_frame_buffer i_lcd_frame_buffer (
      .clk   (clk),
      .rst_n (rst_n),
      .row_1 (row_1),
      .row_2 (row_2),
      .fetch (i_fetch_if.buffer)
   );

   lcd_timer i_lcd_timer (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (timer_start),
      .cycles (timer_cycles),
      .done   (timer_done)
   );

   lcd_sequencer i_lcd_sequencer (
      .clk      (clk),
      .rst_n    (rst_n),
      .done     (timer_done),
      .start    (timer_start),
      .cycles   (timer_cycles),
      .fetch    (i_fetch_if.seq),
      .lcd_en   (lcd_en),
      .lcd_rs   (lcd_rs),
      .lcd_data (lcd_data)
   );

   assign lcd_rw = 1'b0; // Write only, the busy flag is never read

endmodule

`default_nettype wire

/* verilog/lcd_fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lcd_fetch_if import lcd_pkg::*; ();

   logic       capture;    // One-cycle strobe, snapshot both rows
   logic       is_cmd;     // High while the init commands are being sent
   logic [1:0] init_index;
   logic       row_sel;    // 0 selects row 1, 1 selects row 2
   col_index_t col;
   lcd_char_t  byte_out;

   // The sequencer side asks for a byte and gets it back in the same cycle
   modport seq (
      output capture, is_cmd, init_index, row_sel, col,
      input  byte_out
   );

   modport buffer (
      input  capture, is_cmd, init_index, row_sel, col,
      output byte_out
   );

endinterface

`default_nettype wire

/* verilog/lcd_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_frame_buffer import lcd_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  lcd_row_t   row_1,
   input  lcd_row_t   row_2,
   lcd_fetch_if.buffer fetch
);

   lcd_row_t  snap_1;   // Row 1 as it will be drawn in the current frame
   lcd_row_t  snap_2;
   lcd_row_t  snap_sel;
   lcd_char_t init_cmd;

   // Both rows are frozen together once per frame, so text never tears mid-frame
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_1 <= {16{CHAR_SPACE}};
         snap_2 <= {16{CHAR_SPACE}};
      end else if (fetch.capture) begin
         snap_1 <= row_1;
         snap_2 <= row_2;
      end
   end

   // Power-on command sequence for the controller
   always_comb begin
      case (fetch.init_index)
         2'd0: init_cmd = CMD_FUNCTION_SET;
         2'd1: init_cmd = CMD_DISPLAY_ON;
         2'd2: init_cmd = CMD_ENTRY_MODE;
         2'd3: init_cmd = CMD_CLEAR; // Last, it needs the long wait
      endcase
   end

   assign snap_sel = fetch.row_sel ? snap_2 : snap_1;

   // Column c sits at element 15-c, which is the bitwise inverse of a 4-bit index
   assign fetch.byte_out = fetch.is_cmd ? init_cmd : snap_sel[~fetch.col];

endmodule

`default_nettype wire

/* verilog/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

   typedef enum logic {
      LIST = 1'b0, // Radio is receiving
      TALK = 1'b1  // Radio is transmitting with an effect applied
   } talk_mode_t;

   // Codes 5 to 7 are not assigned to any effect
   typedef enum logic [2:0] {
      NORMAL  = 3'd0,
      ECHO    = 3'd1,
      TREMOLO = 3'd2,
      REVERB  = 3'd3,
      SOFT    = 3'd4
   } effect_t;

   typedef logic [7:0] lcd_char_t; // ASCII code, 8'hFF is a solid block on the HD44780 ROM

   localparam lcd_char_t CHAR_SPACE = 8'h20;
   localparam lcd_char_t CHAR_FILL  = 8'hFF;

   // Element 15 is column 0, so a string literal lands left to right on the glass
   typedef lcd_char_t [15:0] lcd_row_t;

   typedef logic [3:0] volume_t;

   typedef enum logic [7:0] {
      CMD_FUNCTION_SET = 8'h38, // 8-bit bus, two lines, 5x8 font
      CMD_DISPLAY_ON   = 8'h0C, // Display on, cursor and blink off
      CMD_ENTRY_MODE   = 8'h06, // Increment address, no shift
      CMD_CLEAR        = 8'h01,
      CMD_ROW1_ADDR    = 8'h80, // DDRAM address 0x00
      CMD_ROW2_ADDR    = 8'hC0  // DDRAM address 0x40
   } lcd_cmd_t;

   localparam int INIT_CMD_COUNT = 4; // FUNCTION_SET, DISPLAY_ON, ENTRY_MODE, CLEAR

   typedef logic [7:0] timer_count_t;

   // Scaled down from the datasheet values to keep simulation short
   localparam timer_count_t LCD_POWERUP_CYCLES    = 8'd40;
   localparam timer_count_t LCD_EN_CYCLES         = 8'd4;
   localparam timer_count_t LCD_WAIT_CYCLES       = 8'd8;
   localparam timer_count_t LCD_CLEAR_WAIT_CYCLES = 8'd32;

   typedef logic [3:0] col_index_t;

   typedef enum logic [2:0] {
      POWERUP, // Wait for the controller to come out of its own reset
      SETUP,   // Data and rs settle before the enable pulse
      PULSE,   // Enable high
      HOLD,    // Enable low while the controller executes
      NEXT     // Pick the next byte
   } seq_state_t;

endpackage

`default_nettype wire

/* verilog/lcd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer import lcd_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         done,
   output logic         start,
   output timer_count_t cycles,
   lcd_fetch_if.seq     fetch,
   output logic         lcd_en,
   output logic         lcd_rs,
   output lcd_char_t    lcd_data
);

   seq_state_t state;
   seq_state_t state_next;
   logic       powerup_armed; // Power-up delay has been started
   logic [1:0] init_idx;
   logic       init_done;
   logic       row_q;         // 0 while row 1 is being written
   col_index_t col_q;
   logic       addr_pending;  // Next byte is a DDRAM address command
   logic       is_clear;
   logic       advance;
   lcd_char_t  byte_sel;
   logic       rs_sel;

   assign fetch.is_cmd     = ~init_done;
   assign fetch.init_index = init_idx;
   assign fetch.row_sel    = row_q;
   assign fetch.col        = col_q;

   // Freeze the text right before the row 1 address goes out
   assign fetch.capture = (state == NEXT) && init_done && addr_pending && !row_q;

   assign is_clear = !lcd_rs && (lcd_data == CMD_CLEAR); // Clear takes far longer than others
   assign advance  = (state == HOLD) && done;

   always_comb begin
      state_next = state;
      start      = 1'b0;
      cycles     = LCD_EN_CYCLES;
      case (state)
         POWERUP: begin
            if (!powerup_armed) begin
               start  = 1'b1;
               cycles = LCD_POWERUP_CYCLES;
            end else if (done) begin
               state_next = NEXT;
            end
         end
         NEXT: begin
            state_next = SETUP; // Byte is latched onto the bus on this edge
         end
         SETUP: begin
            start      = 1'b1;
            cycles     = LCD_EN_CYCLES;
            state_next = PULSE;
         end
         PULSE: begin
            if (done) begin
               start      = 1'b1;
               cycles     = is_clear ? LCD_CLEAR_WAIT_CYCLES : LCD_WAIT_CYCLES;
               state_next = HOLD;
            end
         end
         HOLD: begin
            if (done) begin
               state_next = NEXT;
            end
         end
         default: state_next = POWERUP;
      endcase
   end

   // Address commands are made here, everything else comes from the frame buffer
   always_comb begin
      if (!init_done) begin
         byte_sel = fetch.byte_out;
         rs_sel   = 1'b0;
      end else if (addr_pending) begin
         byte_sel = row_q ? CMD_ROW2_ADDR : CMD_ROW1_ADDR;
         rs_sel   = 1'b0;
      end else begin
         byte_sel = fetch.byte_out;
         rs_sel   = 1'b1; // Data register write
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= POWERUP;
         powerup_armed <= 1'b0;
         lcd_en        <= 1'b0;
         lcd_rs        <= 1'b0;
      end else begin
         state  <= state_next;
         lcd_en <= (state_next == PULSE); // Registered so the pin never glitches
         if (state == POWERUP) begin
            powerup_armed <= 1'b1;
         end
         if (state == NEXT) begin
            lcd_rs <= rs_sel;
         end
      end
   end

   // Loaded once per byte and left alone until after HOLD
   always_ff @(posedge clk) begin
      if (state == NEXT) begin
         lcd_data <= byte_sel;
      end
   end

   // Position moves on once the controller has finished with the current byte
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_idx     <= '0;
         init_done    <= 1'b0;
         row_q        <= 1'b0;
         col_q        <= '0;
         addr_pending <= 1'b0;
      end else if (advance) begin
         if (!init_done) begin
            if (init_idx == 2'(INIT_CMD_COUNT - 1)) begin
               init_done    <= 1'b1;
               addr_pending <= 1'b1; // First frame opens with the row 1 address
            end else begin
               init_idx <= init_idx + 2'd1;
            end
         end else if (addr_pending) begin
            addr_pending <= 1'b0;
         end else if (col_q == 4'd15) begin
            col_q        <= '0;
            row_q        <= ~row_q; // Row 2 after row 1, then back to a new frame
            addr_pending <= 1'b1;
         end else begin
            col_q <= col_q + 4'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/lcd_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_timer import lcd_pkg::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         start,
   input  timer_count_t cycles,
   output logic         done
);

   timer_count_t count; // Zero means idle

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (start) begin
         count <= cycles;          // Restarting mid-count simply reloads
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   // Loaded with N on the start edge, the count reaches 1 exactly N cycles after start
   assign done = (count == timer_count_t'(1));

endmodule

`default_nettype wire
